// ==== Bender.yml ====
package:
  name: afifo_asym

sources:
  - afifo_pkg.sv
  - gray_counter.sv
  - afifo_wr_ctrl.sv
  - afifo_rd_ctrl.sv
  - afifo_asym_mem.sv
  - afifo_asym.sv
  - target: test
    files:
      - tb_afifo_asym.sv

// ==== afifo_asym.sv ====
`timescale 1ns/1ps

module afifo_asym #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int W_ADDR_W = 3,
   parameter int R_ADDR_W = 5
) (
   input  logic                clk,
   input  logic                rd_clk,
   input  logic                rst,

   // write port, clk domain
   input  logic [W_DATA_W-1:0] data_in,
   input  logic                write_en,
   output logic                full,
   output logic [W_ADDR_W-1:0] level_w,

   // read port, rd_clk domain
   input  logic                read_en,
   output logic [R_DATA_W-1:0] data_out,
   output logic                empty,
   output logic [R_ADDR_W-1:0] level_r
);

   logic                write_accept;
   logic [W_ADDR_W-1:0] wr_addr;
   logic [W_ADDR_W-1:0] wr_ptr_gray;

   logic                read_accept;
   logic [R_ADDR_W-1:0] rd_addr;
   logic [R_ADDR_W-1:0] rd_ptr_gray;

   afifo_wr_ctrl #(
      .W_ADDR_W (W_ADDR_W),
      .R_ADDR_W (R_ADDR_W)
   ) i_wr_ctrl (
      .clk          (clk),
      .rst          (rst),
      .write_en     (write_en),
      .rd_ptr_gray  (rd_ptr_gray),
      .write_accept (write_accept),
      .wr_addr      (wr_addr),
      .wr_ptr_gray  (wr_ptr_gray),
      .full         (full),
      .level_w      (level_w)
   );

   afifo_rd_ctrl #(
      .W_ADDR_W (W_ADDR_W),
      .R_ADDR_W (R_ADDR_W)
   ) i_rd_ctrl (
      .rd_clk      (rd_clk),
      .rst         (rst),
      .read_en     (read_en),
      .wr_ptr_gray (wr_ptr_gray),
      .read_accept (read_accept),
      .rd_addr     (rd_addr),
      .rd_ptr_gray (rd_ptr_gray),
      .empty       (empty),
      .level_r     (level_r)
   );

   afifo_asym_mem #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .W_ADDR_W (W_ADDR_W),
      .R_ADDR_W (R_ADDR_W)
   ) i_mem (
      .clk      (clk),
      .wr_en    (write_accept),
      .wr_addr  (wr_addr),
      .data_in  (data_in),
      .rd_clk   (rd_clk),
      .rst      (rst),
      .rd_en    (read_accept),
      .rd_addr  (rd_addr),
      .data_out (data_out)
   );

endmodule

// ==== afifo_asym_mem.sv ====
`timescale 1ns/1ps

module afifo_asym_mem #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int W_ADDR_W = 3,
   parameter int R_ADDR_W = 5
) (
   input  logic                clk,
   input  logic                wr_en,
   input  logic [W_ADDR_W-1:0] wr_addr,
   input  logic [W_DATA_W-1:0] data_in,
   input  logic                rd_clk,
   input  logic                rst,
   input  logic                rd_en,
   input  logic [R_ADDR_W-1:0] rd_addr,
   output logic [R_DATA_W-1:0] data_out
);

   localparam int DEPTH  = 1 << W_ADDR_W;
   localparam int LANES  = afifo_pkg::lane_count(W_DATA_W, R_DATA_W);
   // number of low read address bits that pick the lane
   localparam int LANE_W = afifo_pkg::max_width(W_ADDR_W, R_ADDR_W) -
                           afifo_pkg::min_width(W_ADDR_W, R_ADDR_W);

   logic [W_DATA_W-1:0] mem [DEPTH];

   logic [W_ADDR_W-1:0] word_sel;
   logic [R_ADDR_W-1:0] lane_sel;
   logic [W_DATA_W-1:0] rd_word;
   logic [R_DATA_W-1:0] rd_lane;

   // wide write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= data_in;
      end
   end

   // high bits pick the word, low bits the lane
   assign word_sel = W_ADDR_W'(rd_addr >> LANE_W);
   assign lane_sel = rd_addr % R_ADDR_W'(LANES);

   assign rd_word = mem[word_sel];

   // lane 0 sits in the lowest bits of the word
   assign rd_lane = rd_word[lane_sel*R_DATA_W +: R_DATA_W];

   // narrow registered read port
   always_ff @(posedge rd_clk or posedge rst) begin
      if (rst) begin
         data_out <= '0;
      end else if (rd_en) begin
         data_out <= rd_lane;
      end
   end

endmodule

// ==== afifo_pkg.sv ====
package afifo_pkg;

   // gray code of up to 16 bits back to binary, only the low width bits are decoded
   function automatic logic [15:0] gray_to_bin(input logic [15:0] gray, input int width);
      logic [15:0] bin;
      bin = '0;
      for (int i = 15; i >= 0; i--) begin
         if (i < width) begin
            if (i == width - 1) begin
               bin[i] = gray[i];
            end else begin
               bin[i] = gray[i] ^ bin[i+1];
            end
         end
      end
      return bin;
   endfunction

   // adjacent values differ in a single bit
   function automatic logic [15:0] bin_to_gray(input logic [15:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   function automatic int max_width(input int a, input int b);
      if (a > b) begin
         return a;
      end
      return b;
   endfunction

   function automatic int min_width(input int a, input int b);
      if (a < b) begin
         return a;
      end
      return b;
   endfunction

   // narrow lanes per wide word
   function automatic int lane_count(input int wide_w, input int narrow_w);
      return max_width(wide_w, narrow_w) / min_width(wide_w, narrow_w);
   endfunction

endpackage

// ==== afifo_rd_ctrl.sv ====
`timescale 1ns/1ps

module afifo_rd_ctrl #(
   parameter int W_ADDR_W = 3,
   parameter int R_ADDR_W = 5
) (
   input  logic                rd_clk,
   input  logic                rst,
   input  logic                read_en,
   input  logic [W_ADDR_W-1:0] wr_ptr_gray,
   output logic                read_accept,
   output logic [R_ADDR_W-1:0] rd_addr,
   output logic [R_ADDR_W-1:0] rd_ptr_gray,
   output logic                empty,
   output logic [R_ADDR_W-1:0] level_r
);

   localparam int ADDR_DIFF = afifo_pkg::max_width(W_ADDR_W, R_ADDR_W) -
                              afifo_pkg::min_width(W_ADDR_W, R_ADDR_W);

   logic [W_ADDR_W-1:0] wr_gray_s1;
   logic [W_ADDR_W-1:0] wr_gray_s2;
   logic [W_ADDR_W-1:0] wr_ptr_bin;
   logic [R_ADDR_W-1:0] wr_ptr_scaled;

   assign read_accept = read_en & ~empty;

   gray_counter #(
      .WIDTH (R_ADDR_W)
   ) i_rd_ptr (
      .clk        (rd_clk),
      .rst        (rst),
      .en         (read_accept),
      .count_bin  (rd_addr),
      .count_gray (rd_ptr_gray)
   );

   // write pointer into the read domain
   always_ff @(posedge rd_clk or posedge rst) begin
      if (rst) begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_ptr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   assign wr_ptr_bin = W_ADDR_W'(afifo_pkg::gray_to_bin(16'(wr_gray_s2), W_ADDR_W));

   // scale after decoding, shifting the gray code would break its encoding
   assign wr_ptr_scaled = R_ADDR_W'(wr_ptr_bin) << ADDR_DIFF;

   // lanes available to read
   assign level_r = wr_ptr_scaled - rd_addr;

   assign empty = (level_r == '0);

endmodule

// ==== afifo_wr_ctrl.sv ====
`timescale 1ns/1ps

module afifo_wr_ctrl #(
   parameter int W_ADDR_W = 3,
   parameter int R_ADDR_W = 5
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                write_en,
   input  logic [R_ADDR_W-1:0] rd_ptr_gray,
   output logic                write_accept,
   output logic [W_ADDR_W-1:0] wr_addr,
   output logic [W_ADDR_W-1:0] wr_ptr_gray,
   output logic                full,
   output logic [W_ADDR_W-1:0] level_w
);

   localparam int DEPTH     = 1 << W_ADDR_W;
   // read pointer counts lanes, write pointer counts words
   localparam int ADDR_DIFF = afifo_pkg::max_width(W_ADDR_W, R_ADDR_W) -
                              afifo_pkg::min_width(W_ADDR_W, R_ADDR_W);

   logic [R_ADDR_W-1:0] rd_gray_s1;
   logic [R_ADDR_W-1:0] rd_gray_s2;
   logic [R_ADDR_W-1:0] rd_ptr_bin;
   logic [W_ADDR_W-1:0] rd_ptr_scaled;

   assign write_accept = write_en & ~full;

   gray_counter #(
      .WIDTH (W_ADDR_W)
   ) i_wr_ptr (
      .clk        (clk),
      .rst        (rst),
      .en         (write_accept),
      .count_bin  (wr_addr),
      .count_gray (wr_ptr_gray)
   );

   // two flop synchronizer for the read pointer
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_ptr_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   assign rd_ptr_bin = R_ADDR_W'(afifo_pkg::gray_to_bin(16'(rd_gray_s2), R_ADDR_W));

   // drop the lane bits, a partly read word still counts as occupied
   assign rd_ptr_scaled = W_ADDR_W'(rd_ptr_bin >> ADDR_DIFF);

   // wraps modulo the depth
   assign level_w = wr_addr - rd_ptr_scaled;

   // one slot kept free so full and empty stay distinguishable
   assign full = (level_w == W_ADDR_W'(DEPTH - 1));

endmodule

// ==== gray_counter.sv ====
`timescale 1ns/1ps

module gray_counter #(
   parameter int WIDTH = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   output logic [WIDTH-1:0] count_bin,
   output logic [WIDTH-1:0] count_gray
);

   logic [WIDTH-1:0] next_bin;
   logic [WIDTH-1:0] next_gray;

   assign next_bin  = count_bin + 1'b1;
   // gray of the next value, so both registers always describe the same count
   assign next_gray = WIDTH'(afifo_pkg::bin_to_gray(16'(next_bin)));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_bin  <= '0;
         count_gray <= '0;
      end else if (en) begin
         count_bin  <= next_bin;
         count_gray <= next_gray;
      end
   end

endmodule

// ==== src.f ====
afifo_pkg.sv
gray_counter.sv
afifo_wr_ctrl.sv
afifo_rd_ctrl.sv
afifo_asym_mem.sv
afifo_asym.sv
tb_afifo_asym.sv

// ==== tb_afifo_asym.sv ====
`timescale 1ns/1ps

module tb_afifo_asym;

   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;
   localparam int W_ADDR_W = 3;
   localparam int R_ADDR_W = 5;
   localparam int LANES    = W_DATA_W / R_DATA_W;

   localparam realtime WR_HALF = 4.0;
   localparam realtime RD_HALF = 6.5;

   localparam int RESET_READS   = 4;
   localparam int FULL_WORDS    = (1 << W_ADDR_W) - 1;
   localparam int RANDOM_CYCLES = 400;
   localparam int PLANNED_OPS   = RESET_READS + FULL_WORDS + 1 + FULL_WORDS * LANES +
                                  2 * RANDOM_CYCLES;
   localparam realtime WATCHDOG_NS = PLANNED_OPS * 20 * (2.0 * RD_HALF);

   logic                clk;
   logic                rd_clk;
   logic                rst;
   logic [W_DATA_W-1:0] data_in;
   logic                write_en;
   logic                full;
   logic [W_ADDR_W-1:0] level_w;
   logic                read_en;
   logic [R_DATA_W-1:0] data_out;
   logic                empty;
   logic [R_ADDR_W-1:0] level_r;

   // one reference entry per narrow lane
   logic [R_DATA_W-1:0] ref_q[$];
   int                  words_written;
   int                  lanes_read;
   logic                check_pending;
   logic [R_DATA_W-1:0] check_lane;

   logic [31:0] wr_seed;
   logic [31:0] rd_seed;

   afifo_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .W_ADDR_W (W_ADDR_W),
      .R_ADDR_W (R_ADDR_W)
   ) i_afifo_asym (
      .clk      (clk),
      .rd_clk   (rd_clk),
      .rst      (rst),
      .data_in  (data_in),
      .write_en (write_en),
      .full     (full),
      .level_w  (level_w),
      .read_en  (read_en),
      .data_out (data_out),
      .empty    (empty),
      .level_r  (level_r)
   );

   always #(WR_HALF) clk = ~clk;
   always #(RD_HALF) rd_clk = ~rd_clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic value_error(input string msg);
      $display("ERR %0t %s", $time, msg);
      $display("test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic run_error(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1, "stopped at first error");
   endtask

   // a write is taken when write_en is high and full is low
   always @(posedge clk) begin
      if (!rst && write_en && !full) begin
         for (int i = 0; i < LANES; i++) begin
            ref_q.push_back(data_in[i*R_DATA_W +: R_DATA_W]);
         end
         words_written++;
      end
   end

   // pop the reference queue on each taken read
   always @(posedge rd_clk) begin
      if (!rst && read_en && !empty) begin
         if (ref_q.size() == 0) begin
            run_error("a read was taken although every written lane had been read");
         end else begin
            check_lane    = ref_q.pop_front();
            check_pending = 1'b1;
            lanes_read++;
         end
      end
   end

   // read side checks on the falling edge
   always @(negedge rd_clk) begin
      if (!rst) begin
         if (check_pending) begin
            assert (data_out == check_lane)
               else value_error($sformatf("data_out %h, expected %h", data_out, check_lane));
            check_pending = 1'b0;
         end
         assert (level_r <= LANES * words_written - lanes_read)
            else value_error($sformatf("level_r %0d above %0d unread lanes", level_r,
                                       LANES * words_written - lanes_read));
         if (ref_q.size() == 0) begin
            assert (empty)
               else value_error("empty low with no unread lanes");
         end
         // read pulses before any write must not disturb the read port
         if (words_written == 0) begin
            assert (data_out == '0 && level_r == '0)
               else value_error($sformatf("before writes data_out %h level_r %0d",
                                          data_out, level_r));
         end
      end
   end

   full_empty_exclusive: assert property (@(posedge clk) disable iff (rst) !(full && empty))
      else value_error("full and empty both high");

   task automatic wait_full(input int max_edges);
      int n;
      n = 0;
      @(negedge clk);
      while (!full && n < max_edges) begin
         @(negedge clk);
         n++;
      end
      if (!full) begin
         run_error("full stayed low after the FIFO was filled");
      end
   endtask

   task automatic wait_write_idle(input int max_edges);
      int n;
      n = 0;
      @(negedge clk);
      while ((full || level_w != '0) && n < max_edges) begin
         @(negedge clk);
         n++;
      end
      if (full || level_w != '0) begin
         run_error("write side did not see the FIFO drained");
      end
   endtask

   // hold read_en until every written lane has come out
   task automatic drain_all(input int max_cycles);
      int cycles;
      cycles = 0;
      @(negedge rd_clk);
      while (lanes_read < LANES * words_written && cycles < max_cycles) begin
         @(posedge rd_clk);
         read_en <= 1'b1;
         @(negedge rd_clk);
         cycles++;
      end
      @(posedge rd_clk);
      read_en <= 1'b0;
      if (lanes_read != LANES * words_written) begin
         run_error("reads stopped before all written lanes came out");
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      run_error("run hung, watchdog expired before the tests finished");
   end

   initial begin
      clk           = 1'b0;
      rd_clk        = 1'b0;
      rst           = 1'b1;
      data_in       = '0;
      write_en      = 1'b0;
      read_en       = 1'b0;
      words_written = 0;
      lanes_read    = 0;
      check_pending = 1'b0;
      check_lane    = '0;
      wr_seed       = 32'hdff8;
      rd_seed       = lcg_next(32'hdff8 ^ 32'h5a5a_0000);

      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // idle state after reset and read pulses on the empty FIFO
      @(negedge clk);
      assert (empty && !full && level_w == '0 && level_r == '0 && data_out == '0)
         else value_error("outputs not at reset values");
      repeat (RESET_READS) begin
         @(posedge rd_clk);
         read_en <= 1'b1;
         @(posedge rd_clk);
         read_en <= 1'b0;
      end
      @(negedge rd_clk);
      assert (lanes_read == 0 && data_out == '0 && level_r == '0 && empty)
         else value_error("read on empty FIFO changed the read side");

      // fill up with no reads
      repeat (FULL_WORDS) begin
         @(posedge clk);
         wr_seed = lcg_next(wr_seed);
         write_en <= 1'b1;
         data_in  <= wr_seed;
      end
      @(posedge clk);
      write_en <= 1'b0;
      wait_full(3);
      assert (level_w == W_ADDR_W'(FULL_WORDS))
         else value_error($sformatf("level_w %0d when full", level_w));

      // a further write while full is dropped
      @(posedge clk);
      wr_seed = lcg_next(wr_seed);
      write_en <= 1'b1;
      data_in  <= wr_seed;
      repeat (2) @(posedge clk);
      write_en <= 1'b0;
      @(negedge clk);
      assert (words_written == FULL_WORDS && full)
         else value_error($sformatf("%0d words taken, expected %0d", words_written,
                                    FULL_WORDS));

      drain_all(200);
      @(negedge rd_clk);
      assert (lanes_read == FULL_WORDS * LANES && empty && level_r == '0)
         else value_error($sformatf("%0d lanes read after draining", lanes_read));
      wait_write_idle(20);

      // random traffic on both clocks at once
      fork
         begin
            repeat (RANDOM_CYCLES) begin
               @(posedge clk);
               wr_seed = lcg_next(wr_seed);
               write_en <= (wr_seed[31:29] == 3'd0);
               wr_seed = lcg_next(wr_seed);
               data_in <= wr_seed;
            end
            @(posedge clk);
            write_en <= 1'b0;
         end
         begin
            repeat (RANDOM_CYCLES) begin
               @(posedge rd_clk);
               rd_seed = lcg_next(rd_seed);
               read_en <= (rd_seed[31:30] != 2'd0);
            end
            @(posedge rd_clk);
            read_en <= 1'b0;
         end
      join

      drain_all(1000);
      @(negedge rd_clk);
      assert (ref_q.size() == 0 && empty && level_r == '0)
         else value_error($sformatf("after random traffic level_r %0d empty %b", level_r,
                                    empty));
      wait_write_idle(20);

      $display("test passed");
      $finish;
   end

endmodule
